//--- src/dcache_consts.svh
/*
 * Geometry and segment codes of the 2-way data cache.
 * Included by the type packages and by any module that sizes arrays or fields.
 */
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

`define DC_TAG_W        20
`define DC_INDEX_W      8
`define DC_OFFSET_W     4

`define DC_SETS         256
`define DC_LINE_WORDS   4

// top three address bits
`define DC_SEG_CACHED   3'b100
`define DC_SEG_UNCACHED 3'b101

`endif

//--- src/cpu_req_pkg.sv
/*
 * Types of the CPU side of the data cache.
 * Address fields, data word, byte strobe and access kind.
 */
`include "dcache_consts.svh"

package cpu_req_pkg;

    typedef logic [`DC_TAG_W-1:0]    tag_t;
    typedef logic [`DC_INDEX_W-1:0]  index_t;
    typedef logic [`DC_OFFSET_W-1:0] offset_t;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;

    typedef logic [`DC_TAG_W+`DC_INDEX_W+`DC_OFFSET_W-1:0] vaddr_t;

    typedef enum logic {
        LOAD,
        STORE
    } op_t;

endpackage

//--- src/mem_bus_pkg.sv
/*
 * Types of the memory side of the data cache, plus the controller states.
 */
`include "dcache_consts.svh"

package mem_bus_pkg;

    typedef logic [`DC_TAG_W+`DC_INDEX_W+`DC_OFFSET_W-1:0] paddr_t;
    typedef logic [`DC_LINE_WORDS*32-1:0]                  line_t;
    typedef logic                                          way_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,      // victim chosen, write-back issued if dirty
        REPLACE,   // waiting for the write-back
        REFILL,
        UNC_WRITE,
        UNC_READ
    } ctrl_state_t;

endpackage

//--- src/addr_translate.sv
/*
 * Fixed-mapping segment translation.
 * Both fixed segments drop their top three bits; the second one is uncached.
 * Anything else passes through and is cached.
 */
`timescale 1ns/100ps
`include "dcache_consts.svh"

module addr_translate (
    input  cpu_req_pkg::vaddr_t vaddr,
    output mem_bus_pkg::paddr_t paddr,
    output logic                uncached
);
    import cpu_req_pkg::*;
    import mem_bus_pkg::*;

    logic [2:0] seg;

    assign seg = vaddr[31:29];

    always_comb begin
        paddr    = vaddr;
        uncached = 1'b0;
        if (seg == `DC_SEG_CACHED || seg == `DC_SEG_UNCACHED) begin
            paddr = {3'b000, vaddr[28:0]};
        end
        if (seg == `DC_SEG_UNCACHED) begin
            uncached = 1'b1;
        end
    end

endmodule

//--- src/req_buffer.sv
/*
 * Input-side request buffer.
 * Captures one CPU request per accept and holds it while the controller works on it.
 */
`timescale 1ns/100ps

module req_buffer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 valid,
    input  cpu_req_pkg::op_t     op,
    input  cpu_req_pkg::tag_t    tag,
    input  cpu_req_pkg::index_t  index,
    input  cpu_req_pkg::offset_t offset,
    input  cpu_req_pkg::word_t   wdata,
    input  cpu_req_pkg::strb_t   wstrb,
    input  logic                 accept_en,
    output logic                 addr_ok,
    output logic                 buf_valid,
    output cpu_req_pkg::op_t     buf_op,
    output cpu_req_pkg::tag_t    buf_tag,
    output cpu_req_pkg::index_t  buf_index,
    output cpu_req_pkg::offset_t buf_offset,
    output cpu_req_pkg::word_t   buf_wdata,
    output cpu_req_pkg::strb_t   buf_wstrb
);
    import cpu_req_pkg::*;

    logic accept;

    assign addr_ok = accept_en;   // stall rules live in the controller
    assign accept  = valid && accept_en;

    always_ff @(posedge clk) begin
        if (reset) begin
            buf_valid <= 1'b0;
        end else if (accept_en) begin
            buf_valid <= valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            buf_op     <= op;
            buf_tag    <= tag;
            buf_index  <= index;
            buf_offset <= offset;
            buf_wdata  <= wdata;
            buf_wstrb  <= wstrb;
        end
    end

    // request must stay put until the next accept window
    held_stable: assert property (@(posedge clk) disable iff (reset)
        buf_valid && !accept |=> $stable({buf_tag, buf_index, buf_offset, buf_wdata, buf_wstrb})
                                 && $stable(buf_op));

endmodule

//--- src/cache_ways.sv
/*
 * Tag, valid, dirty and data storage for both ways, with hit detection.
 * Read starts at acceptance on rd_index; compare happens at the held look_index.
 * Writes are word-enabled at look_index. One round-robin bit per set picks the victim.
 */
`timescale 1ns/100ps
`include "dcache_consts.svh"

module cache_ways (
    input  logic                clk,
    input  logic                reset,
    input  cpu_req_pkg::index_t rd_index,
    input  cpu_req_pkg::index_t look_index,
    input  cpu_req_pkg::tag_t   look_tag,
    input  logic                wr_en,
    input  mem_bus_pkg::way_t   wr_way,
    input  logic [3:0]          wr_word_en,
    input  mem_bus_pkg::line_t  wr_line,
    input  cpu_req_pkg::tag_t   wr_tag,
    input  logic                set_dirty,
    input  logic                bump_repl,
    output logic                hit,
    output mem_bus_pkg::way_t   hit_way,
    output mem_bus_pkg::line_t  hit_line,
    output mem_bus_pkg::way_t   victim_way,
    output logic                victim_dirty,
    output cpu_req_pkg::tag_t   victim_tag,
    output mem_bus_pkg::line_t  victim_line
);
    import cpu_req_pkg::*;
    import mem_bus_pkg::*;

    tag_t                tag_mem  [2][`DC_SETS];
    line_t               data_mem [2][`DC_SETS];
    logic [`DC_SETS-1:0] valid_q  [2];
    logic [`DC_SETS-1:0] dirty_q  [2];
    logic [`DC_SETS-1:0] repl_q;

    tag_t   rd_tag_q  [2];
    line_t  rd_line_q [2];
    index_t rd_index_q;
    logic   wr_seen;
    logic   use_q;
    tag_t   cur_tag   [2];
    line_t  cur_line  [2];
    logic [1:0] way_hit;

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            rd_tag_q[w]  <= tag_mem[w][rd_index];
            rd_line_q[w] <= data_mem[w][rd_index];
        end
        rd_index_q <= rd_index;
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_way][look_index] <= wr_tag;
            for (int k = 0; k < `DC_LINE_WORDS; k++) begin
                if (wr_word_en[k]) begin
                    data_mem[wr_way][look_index][k*32 +: 32] <= wr_line[k*32 +: 32];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q[0] <= '0;
            valid_q[1] <= '0;
            dirty_q[0] <= '0;
            dirty_q[1] <= '0;
            repl_q     <= '0;
            wr_seen    <= 1'b1;
        end else begin
            wr_seen <= wr_en;
            if (wr_en) begin
                valid_q[wr_way][look_index] <= 1'b1;
                if (set_dirty) begin
                    dirty_q[wr_way][look_index] <= 1'b1;
                end else if (&wr_word_en) begin
                    dirty_q[wr_way][look_index] <= 1'b0;   // clean refill
                end
            end
            if (bump_repl) begin
                repl_q[look_index] <= ~repl_q[look_index];
            end
        end
    end

    // registered copy is stale after a write or when the held set differs
    assign use_q = (rd_index_q == look_index) && !wr_seen;

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            cur_tag[w]  = use_q ? rd_tag_q[w]  : tag_mem[w][look_index];
            cur_line[w] = use_q ? rd_line_q[w] : data_mem[w][look_index];
            way_hit[w]  = valid_q[w][look_index] && (cur_tag[w] == look_tag);
        end
    end

    assign hit      = |way_hit;
    assign hit_way  = way_hit[1];
    assign hit_line = cur_line[hit_way];

    assign victim_way   = repl_q[look_index];
    assign victim_dirty = valid_q[victim_way][look_index] && dirty_q[victim_way][look_index];
    assign victim_tag   = cur_tag[victim_way];
    assign victim_line  = cur_line[victim_way];

    // refill only follows a miss, so a tag never lands in both ways
    single_hit: assert property (@(posedge clk) disable iff (reset) !(&way_hit));

endmodule

//--- src/cache_ctrl.sv
/*
 * Lookup / miss / refill controller of the data cache.
 * Hits finish in LOOKUP; misses write back a dirty victim, refill and look up again.
 * Uncached accesses go out as single words on the word bus.
 */
`timescale 1ns/100ps
`include "dcache_consts.svh"

module cache_ctrl (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 valid,
    input  logic                 buf_valid,
    input  cpu_req_pkg::op_t     buf_op,
    input  cpu_req_pkg::index_t  buf_index,
    input  cpu_req_pkg::offset_t buf_offset,
    input  cpu_req_pkg::word_t   buf_wdata,
    input  cpu_req_pkg::strb_t   buf_wstrb,
    input  mem_bus_pkg::paddr_t  paddr,
    input  logic                 uncached,
    input  logic                 hit,
    input  mem_bus_pkg::way_t    hit_way,
    input  mem_bus_pkg::line_t   hit_line,
    input  mem_bus_pkg::way_t    victim_way,
    input  logic                 victim_dirty,
    input  cpu_req_pkg::tag_t    victim_tag,
    input  mem_bus_pkg::line_t   victim_line,
    input  logic                 bus_done,
    input  mem_bus_pkg::line_t   bus_line,
    input  cpu_req_pkg::word_t   bus_word,
    output logic                 accept_en,
    output logic                 data_ok,
    output cpu_req_pkg::word_t   rdata,
    output logic                 wr_en,
    output mem_bus_pkg::way_t    wr_way,
    output logic [3:0]           wr_word_en,
    output mem_bus_pkg::line_t   wr_line,
    output cpu_req_pkg::tag_t    wr_tag,
    output logic                 set_dirty,
    output logic                 bump_repl,
    output logic                 start_line_rd,
    output logic                 start_line_wr,
    output logic                 start_word_rd,
    output logic                 start_word_wr,
    output mem_bus_pkg::paddr_t  bus_addr,
    output mem_bus_pkg::line_t   bus_wline,
    output cpu_req_pkg::word_t   bus_wword,
    output cpu_req_pkg::strb_t   bus_wstrb
);
    import cpu_req_pkg::*;
    import mem_bus_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;
    logic        st_pend;      // store hit write, one cycle after LOOKUP
    logic        is_store;
    logic        lookup_hit;
    logic [1:0]  word_sel;

    function automatic line_t merge_store(line_t line, logic [1:0] sel, word_t data,
                                          strb_t strb);
        line_t merged;
        merged = line;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                merged[sel*32 + b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    assign is_store   = (buf_op == STORE);
    assign word_sel   = buf_offset[`DC_OFFSET_W-1:2];
    assign lookup_hit = (state == LOOKUP) && buf_valid && !uncached && hit;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= IDLE;
            st_pend <= 1'b0;
        end else begin
            state   <= next_state;
            st_pend <= lookup_hit && is_store;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: if (valid && accept_en) next_state = LOOKUP;
            LOOKUP: begin
                if (uncached) begin
                    next_state = is_store ? UNC_WRITE : UNC_READ;
                end else if (!lookup_hit) begin
                    next_state = MISS;
                end else if (!(valid && accept_en)) begin
                    next_state = IDLE;   // else a pipelined request stays in LOOKUP
                end
            end
            MISS:                next_state = victim_dirty ? REPLACE : REFILL;
            REPLACE:             if (bus_done) next_state = REFILL;
            REFILL:              if (bus_done) next_state = LOOKUP;
            UNC_WRITE, UNC_READ: if (bus_done) next_state = IDLE;
            default:             next_state = IDLE;
        endcase
    end

    assign accept_en = (state == IDLE) || (lookup_hit && !is_store);
    assign data_ok   = lookup_hit || ((state == UNC_WRITE || state == UNC_READ) && bus_done);
    assign rdata     = (state == UNC_READ) ? bus_word : hit_line[word_sel*32 +: 32];

    always_comb begin
        wr_en      = 1'b0;
        wr_way     = hit_way;
        wr_word_en = 4'b0001 << word_sel;
        wr_line    = merge_store(hit_line, word_sel, buf_wdata, buf_wstrb);
        set_dirty  = 1'b1;
        bump_repl  = 1'b0;
        if (st_pend) begin
            wr_en = 1'b1;
        end else if (state == REFILL && bus_done) begin
            wr_en      = 1'b1;
            wr_way     = victim_way;
            wr_word_en = '1;
            wr_line    = is_store ? merge_store(bus_line, word_sel, buf_wdata, buf_wstrb)
                                  : bus_line;
            set_dirty  = is_store;
            bump_repl  = 1'b1;
        end
    end

    assign wr_tag = paddr[31 -: `DC_TAG_W];

    assign start_word_wr = (state == LOOKUP) && uncached && is_store;
    assign start_word_rd = (state == LOOKUP) && uncached && !is_store;
    assign start_line_wr = (state == MISS) && victim_dirty;
    assign start_line_rd = ((state == MISS) && !victim_dirty) || ((state == REPLACE) && bus_done);

    always_comb begin
        if (start_line_wr) begin
            bus_addr = {victim_tag, buf_index, {`DC_OFFSET_W{1'b0}}};   // victim line
        end else if (uncached) begin
            bus_addr = paddr;
        end else begin
            bus_addr = {paddr[31:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};
        end
    end

    assign bus_wline = victim_line;
    assign bus_wword = buf_wdata;
    assign bus_wstrb = buf_wstrb;

    no_ok_in_idle: assert property (@(posedge clk) disable iff (reset)
        (state == IDLE) |-> !data_ok);

endmodule

//--- src/bus_port.sv
/*
 * Output-side bus port.
 * Turns start pulses into held line or word requests that drop on their rdy handshake.
 * bus_done marks a write handshake or returned read data.
 */
`timescale 1ns/100ps

module bus_port (
    input  logic                clk,
    input  logic                reset,
    input  logic                start_line_rd,
    input  logic                start_line_wr,
    input  logic                start_word_rd,
    input  logic                start_word_wr,
    input  mem_bus_pkg::paddr_t bus_addr,
    input  mem_bus_pkg::line_t  bus_wline,
    input  cpu_req_pkg::word_t  bus_wword,
    input  cpu_req_pkg::strb_t  bus_wstrb,
    output logic                rd_req,
    output mem_bus_pkg::paddr_t rd_addr,
    input  logic                rd_rdy,
    input  logic                ret_valid,
    input  mem_bus_pkg::line_t  ret_data,
    output logic                wr_req,
    output mem_bus_pkg::paddr_t wr_addr,
    output mem_bus_pkg::line_t  wr_data,
    input  logic                wr_rdy,
    output logic                ud_rd_req,
    output mem_bus_pkg::paddr_t ud_rd_addr,
    input  logic                ud_rd_rdy,
    input  logic                ud_ret_valid,
    input  cpu_req_pkg::word_t  ud_ret_data,
    output logic                ud_wr_req,
    output mem_bus_pkg::paddr_t ud_wr_addr,
    output cpu_req_pkg::word_t  ud_wr_data,
    output cpu_req_pkg::strb_t  ud_wr_strb,
    input  logic                ud_wr_rdy,
    output logic                bus_done,
    output mem_bus_pkg::line_t  bus_line,
    output cpu_req_pkg::word_t  bus_word
);
    import cpu_req_pkg::*;
    import mem_bus_pkg::*;

    paddr_t addr_q;   // one request at a time, so one address
    line_t  line_q;
    word_t  word_q;
    strb_t  strb_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_req    <= 1'b0;
            wr_req    <= 1'b0;
            ud_rd_req <= 1'b0;
            ud_wr_req <= 1'b0;
        end else begin
            if (start_line_rd) rd_req <= 1'b1;
            else if (rd_req && rd_rdy) rd_req <= 1'b0;
            if (start_line_wr) wr_req <= 1'b1;
            else if (wr_req && wr_rdy) wr_req <= 1'b0;
            if (start_word_rd) ud_rd_req <= 1'b1;
            else if (ud_rd_req && ud_rd_rdy) ud_rd_req <= 1'b0;
            if (start_word_wr) ud_wr_req <= 1'b1;
            else if (ud_wr_req && ud_wr_rdy) ud_wr_req <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start_line_rd || start_line_wr || start_word_rd || start_word_wr) begin
            addr_q <= bus_addr;
        end
        if (start_line_wr) line_q <= bus_wline;
        if (start_word_wr) begin
            word_q <= bus_wword;
            strb_q <= bus_wstrb;
        end
    end

    assign rd_addr    = addr_q;
    assign wr_addr    = addr_q;
    assign wr_data    = line_q;
    assign ud_rd_addr = addr_q;
    assign ud_wr_addr = addr_q;
    assign ud_wr_data = word_q;
    assign ud_wr_strb = strb_q;

    // reads end on returned data, writes on the handshake
    assign bus_done = ret_valid || ud_ret_valid || (wr_req && wr_rdy) || (ud_wr_req && ud_wr_rdy);
    assign bus_line = ret_data;
    assign bus_word = ud_ret_data;

    one_pending: assert property (@(posedge clk) disable iff (reset)
        $onehot0({rd_req, wr_req, ud_rd_req, ud_wr_req}));

endmodule

//--- src/dcache_top.sv
/*
 * Data cache top level.
 * Request buffer and translation feed the controller and way arrays,
 * and the bus port drives the line and word buses.
 */
`timescale 1ns/100ps

module dcache_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 valid,
    input  cpu_req_pkg::op_t     op,
    input  cpu_req_pkg::index_t  index,
    input  cpu_req_pkg::tag_t    tag,
    input  cpu_req_pkg::offset_t offset,
    input  cpu_req_pkg::word_t   wdata,
    input  cpu_req_pkg::strb_t   wstrb,
    output logic                 addr_ok,
    output logic                 data_ok,
    output cpu_req_pkg::word_t   rdata,
    output logic                 rd_req,
    output mem_bus_pkg::paddr_t  rd_addr,
    input  logic                 rd_rdy,
    input  logic                 ret_valid,
    input  mem_bus_pkg::line_t   ret_data,
    output logic                 wr_req,
    output mem_bus_pkg::paddr_t  wr_addr,
    output mem_bus_pkg::line_t   wr_data,
    input  logic                 wr_rdy,
    output logic                 ud_rd_req,
    output mem_bus_pkg::paddr_t  ud_rd_addr,
    input  logic                 ud_rd_rdy,
    input  logic                 ud_ret_valid,
    input  cpu_req_pkg::word_t   ud_ret_data,
    output logic                 ud_wr_req,
    output mem_bus_pkg::paddr_t  ud_wr_addr,
    output cpu_req_pkg::word_t   ud_wr_data,
    output cpu_req_pkg::strb_t   ud_wr_strb,
    input  logic                 ud_wr_rdy
);
    import cpu_req_pkg::*;
    import mem_bus_pkg::*;

    logic    accept_en, buf_valid, uncached;
    op_t     buf_op;
    tag_t    buf_tag, phys_tag, victim_tag;
    index_t  buf_index;
    offset_t buf_offset;
    word_t   buf_wdata, bus_wword, bus_word;
    strb_t   buf_wstrb, bus_wstrb;
    paddr_t  paddr, bus_addr;
    logic    hit, victim_dirty, wr_en, set_dirty, bump_repl, bus_done;
    way_t    hit_way, victim_way, wr_way;
    line_t   hit_line, victim_line, wr_line, bus_wline, bus_line;
    logic [3:0] wr_word_en;
    logic    start_line_rd, start_line_wr, start_word_rd, start_word_wr;

    req_buffer u_req_buffer (
        .clk, .reset, .valid, .op, .tag, .index, .offset, .wdata, .wstrb,
        .accept_en, .addr_ok, .buf_valid, .buf_op, .buf_tag, .buf_index,
        .buf_offset, .buf_wdata, .buf_wstrb
    );

    addr_translate u_addr_translate (
        .vaddr({buf_tag, buf_index, buf_offset}), .paddr, .uncached
    );

    // array read starts on the incoming index
    cache_ways u_cache_ways (
        .clk, .reset, .rd_index(index), .look_index(buf_index), .look_tag(phys_tag),
        .wr_en, .wr_way, .wr_word_en, .wr_line, .wr_tag(phys_tag), .set_dirty, .bump_repl,
        .hit, .hit_way, .hit_line, .victim_way, .victim_dirty, .victim_tag, .victim_line
    );

    cache_ctrl u_cache_ctrl (
        .clk, .reset, .valid, .buf_valid, .buf_op, .buf_index, .buf_offset, .buf_wdata,
        .buf_wstrb, .paddr, .uncached, .hit, .hit_way, .hit_line, .victim_way,
        .victim_dirty, .victim_tag, .victim_line, .bus_done, .bus_line, .bus_word,
        .accept_en, .data_ok, .rdata, .wr_en, .wr_way, .wr_word_en, .wr_line,
        .wr_tag(phys_tag), .set_dirty, .bump_repl, .start_line_rd, .start_line_wr,
        .start_word_rd, .start_word_wr, .bus_addr, .bus_wline, .bus_wword, .bus_wstrb
    );

    bus_port u_bus_port (
        .clk, .reset, .start_line_rd, .start_line_wr, .start_word_rd, .start_word_wr,
        .bus_addr, .bus_wline, .bus_wword, .bus_wstrb,
        .rd_req, .rd_addr, .rd_rdy, .ret_valid, .ret_data,
        .wr_req, .wr_addr, .wr_data, .wr_rdy,
        .ud_rd_req, .ud_rd_addr, .ud_rd_rdy, .ud_ret_valid, .ud_ret_data,
        .ud_wr_req, .ud_wr_addr, .ud_wr_data, .ud_wr_strb, .ud_wr_rdy,
        .bus_done, .bus_line, .bus_word
    );

endmodule

//--- sim/mem_model.sv
/*
 * Testbench memory of 64 KiB behind the line bus and the word bus.
 * Each rdy comes after a random 0 to 3 cycle delay; outputs change on the falling edge.
 * The last write-back address and the last word write address and strobe are kept.
 */
`timescale 1ns/100ps

module mem_model (
    input  logic                clk,
    input  logic                reset,
    input  logic                rd_req,
    input  mem_bus_pkg::paddr_t rd_addr,
    output logic                rd_rdy,
    output logic                ret_valid,
    output mem_bus_pkg::line_t  ret_data,
    input  logic                wr_req,
    input  mem_bus_pkg::paddr_t wr_addr,
    input  mem_bus_pkg::line_t  wr_data,
    output logic                wr_rdy,
    input  logic                ud_rd_req,
    input  mem_bus_pkg::paddr_t ud_rd_addr,
    output logic                ud_rd_rdy,
    output logic                ud_ret_valid,
    output cpu_req_pkg::word_t  ud_ret_data,
    input  logic                ud_wr_req,
    input  mem_bus_pkg::paddr_t ud_wr_addr,
    input  cpu_req_pkg::word_t  ud_wr_data,
    input  cpu_req_pkg::strb_t  ud_wr_strb,
    output logic                ud_wr_rdy,
    output mem_bus_pkg::paddr_t wb_addr_seen,
    output mem_bus_pkg::paddr_t ud_addr_seen,
    output cpu_req_pkg::strb_t  ud_strb_seen
);
    import cpu_req_pkg::*;
    import mem_bus_pkg::*;

    word_t  mem [0:16383];
    integer seed = 32'h14c9;
    int     delay [4];   // line rd, line wr, word rd, word wr
    logic   pend  [4];

    // counts down the random delay of one channel, true when rdy may rise
    function automatic logic ready_now(int ch);
        if (!pend[ch]) begin
            pend[ch]  = 1'b1;
            delay[ch] = $unsigned($random(seed)) % 4;
        end
        if (delay[ch] == 0) begin
            pend[ch] = 1'b0;
            return 1'b1;
        end
        delay[ch]--;
        return 1'b0;
    endfunction

    task automatic poke_word(input paddr_t addr, input word_t data);
        mem[addr[15:2]] = data;
    endtask

    initial begin
        logic [15:0] a;
        for (int i = 0; i < 16384; i++) begin
            a      = i << 2;
            mem[i] = {~a, a};   // depends on every address bit
        end
        for (int ch = 0; ch < 4; ch++) begin
            pend[ch]  = 1'b0;
            delay[ch] = 0;
        end
        {rd_rdy, ret_valid, wr_rdy, ud_rd_rdy, ud_ret_valid, ud_wr_rdy} = '0;
        ret_data     = '0;
        ud_ret_data  = '0;
        wb_addr_seen = '0;
        ud_addr_seen = '0;
        ud_strb_seen = '0;
    end

    always @(negedge clk) begin
        if (reset) begin
            {rd_rdy, ret_valid, wr_rdy, ud_rd_rdy, ud_ret_valid, ud_wr_rdy} <= '0;
        end else begin
            ret_valid    <= 1'b0;
            ud_ret_valid <= 1'b0;
            if (rd_rdy) begin   // handshake done at the last rising edge
                rd_rdy    <= 1'b0;
                ret_valid <= 1'b1;
                for (int k = 0; k < 4; k++) begin
                    ret_data[k*32 +: 32] <= mem[{rd_addr[15:4], 2'(k)}];
                end
            end else if (rd_req && ready_now(0)) begin
                rd_rdy <= 1'b1;
            end
            if (wr_rdy) begin
                wr_rdy <= 1'b0;
            end else if (wr_req && ready_now(1)) begin
                wr_rdy <= 1'b1;
                for (int k = 0; k < 4; k++) begin
                    mem[{wr_addr[15:4], 2'(k)}] = wr_data[k*32 +: 32];
                end
                wb_addr_seen <= wr_addr;
            end
            if (ud_rd_rdy) begin
                ud_rd_rdy    <= 1'b0;
                ud_ret_valid <= 1'b1;
                ud_ret_data  <= mem[ud_rd_addr[15:2]];
            end else if (ud_rd_req && ready_now(2)) begin
                ud_rd_rdy <= 1'b1;
            end
            if (ud_wr_rdy) begin
                ud_wr_rdy <= 1'b0;
            end else if (ud_wr_req && ready_now(3)) begin
                ud_wr_rdy <= 1'b1;
                for (int b = 0; b < 4; b++) begin
                    if (ud_wr_strb[b]) mem[ud_wr_addr[15:2]][b*8 +: 8] = ud_wr_data[b*8 +: 8];
                end
                ud_addr_seen <= ud_wr_addr;
                ud_strb_seen <= ud_wr_strb;
            end
        end
    end

endmodule

//--- sim/dcache_tb.sv
/*
 * Testbench of the data cache.
 * Reads the access trace, drives the CPU port on the falling edge and checks
 * every data_ok, the latency and spacing of expected hits and the bus addresses.
 */
`timescale 1ns/100ps

module dcache_tb;
    import cpu_req_pkg::*;
    import mem_bus_pkg::*;

    logic    clk, reset, valid;
    op_t     op;
    index_t  index;
    tag_t    tag;
    offset_t offset;
    word_t   wdata, rdata, ud_ret_data, ud_wr_data;
    strb_t   wstrb, ud_wr_strb, ud_strb_seen;
    logic    addr_ok, data_ok;
    logic    rd_req, rd_rdy, ret_valid, wr_req, wr_rdy;
    logic    ud_rd_req, ud_rd_rdy, ud_ret_valid, ud_wr_req, ud_wr_rdy;
    paddr_t  rd_addr, wr_addr, ud_rd_addr, ud_wr_addr, wb_addr_seen, ud_addr_seen;
    line_t   ret_data, wr_data;

    logic [31:0] trace_mem [0:511];   // five words per access
    int    cycle;
    int    errors;
    word_t exp_q[$];
    bit    chk_q[$];
    bit    tim_q[$];
    int    acc_q[$];
    int    last_acc;
    logic [31:0] last_kind;

    dcache_top UUT (.*);

    mem_model mem_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(negedge clk) cycle++;

    task automatic stop_with_error(input string why);
        errors++;
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
            stop_with_error($sformatf("MISMATCH at %0t: %s got %h expected %h",
                                      $time, name, got, exp));
    endtask

    task automatic check_paddr(input string name, input paddr_t got, input paddr_t exp);
        if (got !== exp)
            stop_with_error($sformatf("MISMATCH at %0t: %s got %h expected %h",
                                      $time, name, got, exp));
    endtask

    task automatic check_strb(input string name, input strb_t got, input strb_t exp);
        if (got !== exp)
            stop_with_error($sformatf("MISMATCH at %0t: %s got %h expected %h",
                                      $time, name, got, exp));
    endtask

    task automatic check_cycles(input string name, input int got, input int exp);
        if (got != exp)
            stop_with_error($sformatf("MISMATCH at %0t: %s got %0d expected %0d",
                                      $time, name, got, exp));
    endtask

    // results come back in acceptance order
    always @(posedge clk) begin
        if (!reset && data_ok) begin
            if (exp_q.size() == 0) begin
                stop_with_error("data_ok came with no request outstanding");
            end else begin
                if (chk_q[0]) check_word("rdata", rdata, exp_q[0]);
                if (tim_q[0]) check_cycles("data_ok latency", cycle - acc_q[0], 1);
                void'(exp_q.pop_front());
                void'(chk_q.pop_front());
                void'(tim_q.pop_front());
                void'(acc_q.pop_front());
            end
        end
    end

    task automatic issue_access(input int n, input logic [31:0] kind, input vaddr_t addr,
                                input word_t data, input strb_t strb, input word_t exp);
        int cnt;
        bit accepted;
        cnt      = 0;
        accepted = 0;
        @(negedge clk);
        valid  = 1'b1;
        op     = (kind == 1) ? STORE : LOAD;
        tag    = addr[31:12];
        index  = addr[11:4];
        offset = addr[3:0];
        wdata  = data;
        wstrb  = strb;
        while (!accepted) begin
            @(posedge clk);
            if (addr_ok) begin
                accepted = 1;
                // two hits in a row pipeline
                if (kind == 5 && last_kind == 5)
                    check_cycles("acceptance gap", cycle - last_acc, 1);
                last_acc = cycle;
                exp_q.push_back(exp);
                chk_q.push_back(kind != 1);
                tim_q.push_back(kind == 5);
                acc_q.push_back(cycle);
            end else begin
                cnt++;
                if (cnt >= 200)
                    stop_with_error($sformatf("access %0d was never accepted", n));
            end
        end
    endtask

    task automatic finish_outstanding(input int n);
        int cnt;
        cnt = 0;
        @(negedge clk);
        valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            cnt++;
            if (cnt >= 200)
                stop_with_error($sformatf("no data_ok for requests before access %0d", n));
        end
    endtask

    initial begin
        int n;
        logic [31:0] kind;
        errors    = 0;
        cycle     = 0;
        last_acc  = 0;
        last_kind = '0;
        reset     = 1'b1;
        valid     = 1'b0;
        op        = LOAD;
        {tag, index, offset} = '0;
        wdata  = '0;
        wstrb  = '0;
        $readmemh("sim/dcache_trace.txt", trace_mem);
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        n = 0;
        while (trace_mem[n*5] !== 32'hf) begin
            kind = trace_mem[n*5];
            case (kind)
                0, 1, 5: issue_access(n, kind, trace_mem[n*5+1], trace_mem[n*5+2],
                                      trace_mem[n*5+3][3:0], trace_mem[n*5+4]);
                2: begin
                    finish_outstanding(n);
                    mem_i.poke_word(trace_mem[n*5+1], trace_mem[n*5+2]);
                end
                3: begin
                    finish_outstanding(n);
                    check_paddr("wr_addr", wb_addr_seen, trace_mem[n*5+1]);
                end
                4: begin
                    finish_outstanding(n);
                    check_paddr("ud_wr_addr", ud_addr_seen, trace_mem[n*5+1]);
                    check_strb("ud_wr_strb", ud_strb_seen, trace_mem[n*5+3][3:0]);
                end
                default: stop_with_error($sformatf("access %0d has an unknown kind", n));
            endcase
            last_kind = kind;
            n++;
        end
        finish_outstanding(n);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+src
src/cpu_req_pkg.sv
src/mem_bus_pkg.sv
src/addr_translate.sv
src/req_buffer.sv
src/cache_ways.sv
src/cache_ctrl.sv
src/bus_port.sv
src/dcache_top.sv
sim/mem_model.sv
sim/dcache_tb.sv

//--- sim/dcache_trace.txt
// kind addr wdata strb expect; kind 0 load, 1 store, 2 poke memory,
// 3 check write-back addr, 4 check word write addr and strb, 5 load that must hit, f end
00000000 80000104 00000000 0 FEFB0104
00000005 80000108 00000000 0 FEF70108
00000005 80000100 00000000 0 FEFF0100
00000005 8000010C 00000000 0 FEF3010C
00000005 80000104 00000000 0 FEFB0104
// partial store, then the merged word
00000001 80000108 11223344 5 00000000
00000005 80000108 00000000 0 FE220144
// three tags in set 0x10 evict the dirty line
00000000 80001100 00000000 0 EEFF1100
00000000 80002100 00000000 0 DEFF2100
00000003 00000100 00000000 0 00000000
00000000 80000108 00000000 0 FE220144
// uncached store and loads
00000001 A0003010 AABBCCDD 3 00000000
00000004 00003010 00000000 3 00000000
00000000 A0003010 00000000 0 CFEFCCDD
00000000 80003010 00000000 0 CFEFCCDD
00000002 00003010 12345678 0 00000000
00000000 A0003010 00000000 0 12345678
00000005 80003010 00000000 0 CFEFCCDD
00000000 00000204 00000000 0 FDFB0204
0000000F 00000000 00000000 0 00000000
